//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = memSubsystemTb
FILELIST = all.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
verilog/memBusPkg.sv
verilog/memBusIf.sv
verilog/memJoin.sv
verilog/memStore.sv
verilog/memSubsystem.sv
bench/memSubsystemTb.sv

//--- bench/memGolden.txt
# client opm addr wdata expOk expRdData excIn expCl1BusExc expCl2BusExc (all hex)
# client 0 injects excIn; opm 0B load, 13 store; ok 1 done, 3 fault
1 13 0000 11110000 1 00000000 0000 0000 0000
2 13 0080 CAFE0080 1 00000000 0000 0000 0000
1 13 0001 22220001 1 00000000 0000 0000 0000
2 13 0081 CAFE0081 1 00000000 0000 0000 0000
1 13 0002 33330002 1 00000000 0000 0000 0000
2 13 0082 CAFE0082 1 00000000 0000 0000 0000
1 13 0003 44440003 1 00000000 0000 0000 0000
2 0B 0082 00000000 1 CAFE0082 0000 0000 0000
1 0B 0000 00000000 1 11110000 0000 0000 0000
2 0B 0080 00000000 1 CAFE0080 0000 0000 0000
1 0B 0003 00000000 1 44440003 0000 0000 0000
2 13 FFFF 12345678 3 00000000 0000 8F21 8F21
1 0B 0001 00000000 1 22220001 0000 0000 0000
2 13 00FE 0BADF00D 1 00000000 0000 0000 0000
1 0B 0002 00000000 1 33330002 0000 0000 0000
2 0B 00FE 00000000 1 0BADF00D 0000 0000 0000
1 13 00FF A5A5A5A5 1 00000000 0000 0000 0000
2 0B 0081 00000000 1 CAFE0081 0000 0000 0000
1 0B 00FF 00000000 1 A5A5A5A5 0000 0000 0000
1 0B 0100 00000000 3 00000000 0000 8F21 8F21
1 13 0001 5555AAAA 1 00000000 0000 0000 0000
1 0B 0001 00000000 1 5555AAAA 0000 0000 0000
0 00 0000 00000000 0 00000000 8005 8005 0000
0 00 0000 00000000 0 00000000 8107 8107 0000
0 00 0000 00000000 0 00000000 8233 0000 8233
0 00 0000 00000000 0 00000000 8F44 8F44 8F44
0 00 0000 00000000 0 00000000 8355 0000 0000
0 00 0000 00000000 0 00000000 0F66 0000 0000

//--- bench/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb import memBusPkg::*; ();

	localparam int MAX_LINES       = 64;
	localparam int CYCLES_PER_LINE = 64;
	localparam int EXC_WAIT        = 8;

	logic      clock;
	logic      reset;
	busExcWord excIn;
	dataWord   cl1OutData;
	wordAddr   cl1Addr;
	opmCode    cl1Opm;
	dataWord   cl1InData;
	okCode     cl1Ok;
	busExcWord cl1BusExc;
	dataWord   cl2OutData;
	wordAddr   cl2Addr;
	opmCode    cl2Opm;
	dataWord   cl2InData;
	okCode     cl2Ok;
	busExcWord cl2BusExc;

	// client 0 marks an exception injection
	int        gClient [MAX_LINES];
	opmCode    gOpm    [MAX_LINES];
	wordAddr   gAddr   [MAX_LINES];
	dataWord   gWrData [MAX_LINES];
	okCode     gOk     [MAX_LINES];
	dataWord   gRdData [MAX_LINES];
	busExcWord gExcIn  [MAX_LINES];
	busExcWord gExc1   [MAX_LINES];
	busExcWord gExc2   [MAX_LINES];

	int        nLines = 0;
	int        errors = 0;
	int        overlaps = 0;
	int        checks = 0;
	int        cycles = 0;
	int        cycleLimit = CYCLES_PER_LINE;
	integer    seed;

	memSubsystem dut_i
	(
		.clock      (clock),
		.reset      (reset),
		.excIn      (excIn),
		.cl1OutData (cl1OutData),
		.cl1Addr    (cl1Addr),
		.cl1Opm     (cl1Opm),
		.cl1InData  (cl1InData),
		.cl1Ok      (cl1Ok),
		.cl1BusExc  (cl1BusExc),
		.cl2OutData (cl2OutData),
		.cl2Addr    (cl2Addr),
		.cl2Opm     (cl2Opm),
		.cl2InData  (cl2InData),
		.cl2Ok      (cl2Ok),
		.cl2BusExc  (cl2BusExc)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("timeout after %0d cycles with %0d errors", cycles, errors + overlaps);
			$display("TEST FAILED");
			$finish;
		end
	end

	// only one client may be acknowledged at a time
	always @(negedge clock)
	begin
		if (!reset && (cl1Ok == OK_OK) && (cl2Ok == OK_OK))
		begin
			overlaps = overlaps + 1;
			$display("both clients see OK_OK in cycle %0d", cycles);
		end
	end

	function automatic okCode okOf(input int cl);
		okOf = (cl == 1) ? cl1Ok : cl2Ok;
	endfunction

	function automatic dataWord inDataOf(input int cl);
		inDataOf = (cl == 1) ? cl1InData : cl2InData;
	endfunction

	task automatic loadGolden();
		int        fd;
		int        rc;
		string     line;
		int        cl;
		opmCode    opm;
		wordAddr   addr;
		dataWord   wr;
		okCode     ok;
		dataWord   rd;
		busExcWord ei;
		busExcWord e1;
		busExcWord e2;
		fd = $fopen("bench/memGolden.txt", "r");
		if (fd == 0)
		begin
			errors = errors + 1;
			$display("cannot open bench/memGolden.txt");
		end
		else
		begin
			while (!$feof(fd) && (nLines < MAX_LINES))
			begin
				rc = $fgets(line, fd);
				if ((rc > 0) && (line[0] != "#"))
				begin
					rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
						cl, opm, addr, wr, ok, rd, ei, e1, e2);
					if (rc == 9)
					begin
						gClient[nLines] = cl;
						gOpm[nLines]    = opm;
						gAddr[nLines]   = addr;
						gWrData[nLines] = wr;
						gOk[nLines]     = ok;
						gRdData[nLines] = rd;
						gExcIn[nLines]  = ei;
						gExc1[nLines]   = e1;
						gExc2[nLines]   = e2;
						nLines++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic driveRequest(input int cl, input opmCode opm, input wordAddr addr,
		input dataWord data);
		if (cl == 1)
		begin
			cl1Opm     <= opm;
			cl1Addr    <= addr;
			cl1OutData <= data;
		end
		else
		begin
			cl2Opm     <= opm;
			cl2Addr    <= addr;
			cl2OutData <= data;
		end
	endtask

	// replays this client's golden lines through the full handshake
	task automatic runClient(input int cl);
		int i;
		int gap;
		for (i = 0; i < nLines; i++)
		begin
			if (gClient[i] == cl)
			begin
				gap = $unsigned($random(seed)) % 4;
				repeat (gap + 1) @(posedge clock);
				driveRequest(cl, gOpm[i], gAddr[i], gWrData[i]);
				do
					@(negedge clock);
				while ((okOf(cl) != OK_OK) && (okOf(cl) != OK_FAULT));
				checks = checks + 1;
				if (okOf(cl) !== gOk[i])
				begin
					errors = errors + 1;
					$display("Error: cl%0dOk entry %0d got %h expected %h",
						cl, i, okOf(cl), gOk[i]);
				end
				// load data is only valid with OK_OK
				if ((gOk[i] == OK_OK) && (gOpm[i] == OPM_LOAD) && (inDataOf(cl) !== gRdData[i]))
				begin
					errors = errors + 1;
					$display("Error: cl%0dInData entry %0d got %h expected %h",
						cl, i, inDataOf(cl), gRdData[i]);
				end
				if (cl1BusExc !== gExc1[i])
				begin
					errors = errors + 1;
					$display("Error: cl1BusExc entry %0d got %h expected %h", i, cl1BusExc, gExc1[i]);
				end
				if (cl2BusExc !== gExc2[i])
				begin
					errors = errors + 1;
					$display("Error: cl2BusExc entry %0d got %h expected %h", i, cl2BusExc, gExc2[i]);
				end
				@(posedge clock);
				driveRequest(cl, OPM_READY, '0, '0);
				do
					@(negedge clock);
				while (okOf(cl) != OK_READY);
			end
		end
	endtask

	task automatic injectException(input int i);
		int waited;
		waited = 0;
		@(posedge clock);
		excIn <= gExcIn[i];
		// a dropped word never shows up on either port
		do
		begin
			@(negedge clock);
			waited++;
		end
		while ((cl1BusExc == '0) && (cl2BusExc == '0) && (waited < EXC_WAIT));
		checks = checks + 1;
		if (cl1BusExc !== gExc1[i])
		begin
			errors = errors + 1;
			$display("Error: cl1BusExc entry %0d got %h expected %h", i, cl1BusExc, gExc1[i]);
		end
		if (cl2BusExc !== gExc2[i])
		begin
			errors = errors + 1;
			$display("Error: cl2BusExc entry %0d got %h expected %h", i, cl2BusExc, gExc2[i]);
		end
		@(posedge clock);
		excIn <= '0;
		waited = 0;
		do
		begin
			@(negedge clock);
			waited++;
		end
		while (((cl1BusExc != '0) || (cl2BusExc != '0)) && (waited < EXC_WAIT));
		if ((cl1BusExc != '0) || (cl2BusExc != '0))
		begin
			errors = errors + 1;
			$display("exception word of entry %0d did not clear", i);
		end
	endtask

	initial
	begin
		int i;
		reset      <= 1'b1;
		excIn      <= '0;
		cl1OutData <= '0;
		cl1Addr    <= '0;
		cl1Opm     <= OPM_READY;
		cl2OutData <= '0;
		cl2Addr    <= '0;
		cl2Opm     <= OPM_READY;
		seed = 32'hf01e;
		loadGolden();
		cycleLimit = CYCLES_PER_LINE * (nLines + 1);
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		// idle bus right after reset
		checks = checks + 1;
		if (cl1Ok !== OK_READY)
		begin
			errors = errors + 1;
			$display("Error: cl1Ok after reset got %h expected %h", cl1Ok, OK_READY);
		end
		if (cl2Ok !== OK_READY)
		begin
			errors = errors + 1;
			$display("Error: cl2Ok after reset got %h expected %h", cl2Ok, OK_READY);
		end
		if (cl1BusExc !== '0)
		begin
			errors = errors + 1;
			$display("Error: cl1BusExc after reset got %h expected 0000", cl1BusExc);
		end
		if (cl2BusExc !== '0)
		begin
			errors = errors + 1;
			$display("Error: cl2BusExc after reset got %h expected 0000", cl2BusExc);
		end
		if (nLines > 0)
		begin
			fork
				runClient(1);
				runClient(2);
			join
			for (i = 0; i < nLines; i++)
			begin
				if (gClient[i] == 0)
					injectException(i);
			end
		end
		else
		begin
			errors = errors + 1;
			$display("no transactions read from bench/memGolden.txt");
		end
		$display("%0d checks, %0d errors, %0d ack overlaps", checks, errors, overlaps);
		if ((errors == 0) && (overlaps == 0))
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/memBusIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memBusIf import memBusPkg::*; ();

	// client to memory
	dataWord   outData;
	wordAddr   addr;
	opmCode    opm;

	// memory to client
	dataWord   inData;
	okCode     ok;
	busExcWord busExc;

	modport client
	(
		output outData, addr, opm,
		input  inData, ok, busExc
	);

	modport memory
	(
		input  outData, addr, opm,
		output inData, ok, busExc
	);

endinterface

`default_nettype wire

//--- verilog/memBusPkg.sv
`default_nettype none

package memBusPkg;

	// widths of the shared bus
	typedef logic [31:0] dataWord;
	typedef logic [15:0] wordAddr;
	typedef logic [4:0]  opmCode;
	typedef logic [1:0]  okCode;
	typedef logic [15:0] busExcWord;
	typedef logic [3:0]  excTarget;
	typedef logic [7:0]  excCause;

	// operation codes driven by a client
	localparam opmCode OPM_READY = 5'h00;
	localparam opmCode OPM_LOAD  = 5'h0B;
	localparam opmCode OPM_STORE = 5'h13;

	// acknowledge codes driven by the memory
	localparam okCode OK_READY = 2'b00;
	localparam okCode OK_OK    = 2'b01;
	localparam okCode OK_HOLD  = 2'b10;
	localparam okCode OK_FAULT = 2'b11;

	// exception word layout
	localparam int EXC_VALID_BIT = 15;
	localparam int EXC_TGT_HI    = 11;
	localparam int EXC_TGT_LO    = 8;
	localparam int EXC_CAUSE_HI  = 7;
	localparam int EXC_CAUSE_LO  = 0;

	// routable exception targets
	localparam excTarget EXC_TGT_C1A = 4'h0;
	localparam excTarget EXC_TGT_C1B = 4'h1;
	localparam excTarget EXC_TGT_C2  = 4'h2;
	localparam excTarget EXC_TGT_ALL = 4'hF;

	localparam excCause EXC_CAUSE_RANGE = 8'h21;

	// backing store size
	localparam int MEM_WORDS     = 256;
	localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {JOIN_IDLE, GRANT1, GRANT2} joinState;
	typedef enum logic [1:0] {STORE_IDLE, WAIT, DONE} storeState;

endpackage

`default_nettype wire

//--- verilog/memJoin.sv
`timescale 1ns/1ps
`default_nettype none

module memJoin import memBusPkg::*;
(
	input logic      clock,
	input logic      reset,
	memBusIf.memory  cl1,
	memBusIf.memory  cl2,
	memBusIf.client  mem
);

	joinState  state;
	joinState  nextState;
	logic      prio;

	// memory side inputs registered on entry
	dataWord   memInDataR;
	okCode     memOkR;
	busExcWord memBusExcR;

	// next values and exit registers toward the memory
	dataWord   memOutDataN;
	wordAddr   memAddrN;
	opmCode    memOpmN;
	dataWord   memOutDataR;
	wordAddr   memAddrR;
	opmCode    memOpmR;

	// next values and exit registers toward the clients
	okCode     cl1OkN;
	okCode     cl2OkN;
	busExcWord cl1BusExcN;
	busExcWord cl2BusExcN;
	dataWord   cl1InDataR;
	dataWord   cl2InDataR;
	okCode     cl1OkR;
	okCode     cl2OkR;
	busExcWord cl1BusExcR;
	busExcWord cl2BusExcR;

	logic      cl1Req;
	logic      cl2Req;

	assign cl1Req = (cl1.opm != OPM_READY);
	assign cl2Req = (cl2.opm != OPM_READY);

	always_comb
	begin
		nextState   = state;
		// the client that is not granted waits on hold
		cl1OkN      = (state == GRANT2) ? OK_HOLD : OK_READY;
		cl2OkN      = (state == GRANT1) ? OK_HOLD : OK_READY;
		memOutDataN = '0;
		memAddrN    = '0;
		memOpmN     = OPM_READY;

		case (state)
			GRANT1:
			begin
				cl1OkN      = memOkR;
				memOutDataN = cl1.outData;
				memAddrN    = cl1.addr;
				memOpmN     = cl1.opm;
				if (!cl1Req && (memOkR == OK_READY))
					nextState = JOIN_IDLE;
			end
			GRANT2:
			begin
				cl2OkN      = memOkR;
				memOutDataN = cl2.outData;
				memAddrN    = cl2.addr;
				memOpmN     = cl2.opm;
				if (!cl2Req && (memOkR == OK_READY))
					nextState = JOIN_IDLE;
			end
			default:
			begin
				// client 2 only wins a tie on the priority phase
				if (cl1Req && !(cl2Req && prio))
					nextState = GRANT1;
				else if (cl2Req)
					nextState = GRANT2;
			end
		endcase
	end

	// exception steering by target field
	always_comb
	begin
		cl1BusExcN = '0;
		cl2BusExcN = '0;
		if (memBusExcR[EXC_VALID_BIT])
		begin
			case (excTarget'(memBusExcR[EXC_TGT_HI:EXC_TGT_LO]))
				EXC_TGT_C1A, EXC_TGT_C1B:
					cl1BusExcN = memBusExcR;
				EXC_TGT_C2:
					cl2BusExcN = memBusExcR;
				EXC_TGT_ALL:
				begin
					cl1BusExcN = memBusExcR;
					cl2BusExcN = memBusExcR;
				end
				default:
				begin
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		prio <= !prio;
		if (reset)
		begin
			state      <= JOIN_IDLE;
			memOkR     <= OK_READY;
			memBusExcR <= '0;
			memOpmR    <= OPM_READY;
			cl1OkR     <= OK_READY;
			cl2OkR     <= OK_READY;
			cl1BusExcR <= '0;
			cl2BusExcR <= '0;
		end
		else
		begin
			state      <= nextState;
			memOkR     <= mem.ok;
			memBusExcR <= mem.busExc;
			memOpmR    <= memOpmN;
			cl1OkR     <= cl1OkN;
			cl2OkR     <= cl2OkN;
			cl1BusExcR <= cl1BusExcN;
			cl2BusExcR <= cl2BusExcN;
		end
	end

	always_ff @(posedge clock)
	begin
		memInDataR  <= mem.inData;
		memOutDataR <= memOutDataN;
		memAddrR    <= memAddrN;
		// load data goes to both clients
		cl1InDataR  <= memInDataR;
		cl2InDataR  <= memInDataR;
	end

	assign mem.outData = memOutDataR;
	assign mem.addr    = memAddrR;
	assign mem.opm     = memOpmR;

	assign cl1.inData  = cl1InDataR;
	assign cl1.ok      = cl1OkR;
	assign cl1.busExc  = cl1BusExcR;
	assign cl2.inData  = cl2InDataR;
	assign cl2.ok      = cl2OkR;
	assign cl2.busExc  = cl2BusExcR;

endmodule

`default_nettype wire

//--- verilog/memStore.sv
`timescale 1ns/1ps
`default_nettype none

module memStore import memBusPkg::*;
(
	input logic       clock,
	input logic       reset,
	memBusIf.memory   bus,
	input busExcWord  excIn
);

	dataWord   mem [MEM_WORDS];
	storeState state;
	logic [1:0] waitCnt;

	okCode     okR;
	dataWord   inDataR;
	busExcWord busExcR;
	busExcWord rangeExc;

	logic      finish;
	logic      fault;
	logic [MEM_ADDR_BITS-1:0] index;

	assign fault  = (bus.addr >= wordAddr'(MEM_WORDS));
	assign finish = (state == WAIT) && (waitCnt == 2'd0);
	assign index  = bus.addr[MEM_ADDR_BITS-1:0];

	// range fault is broadcast to every client
	always_comb
	begin
		rangeExc = '0;
		rangeExc[EXC_VALID_BIT] = 1'b1;
		rangeExc[EXC_TGT_HI:EXC_TGT_LO] = EXC_TGT_ALL;
		rangeExc[EXC_CAUSE_HI:EXC_CAUSE_LO] = EXC_CAUSE_RANGE;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state   <= STORE_IDLE;
			waitCnt <= 2'd0;
			okR     <= OK_READY;
			busExcR <= '0;
		end
		else
		begin
			busExcR <= (finish && fault) ? rangeExc : excIn;
			case (state)
				STORE_IDLE:
				begin
					okR <= OK_READY;
					if (bus.opm != OPM_READY)
					begin
						// hold length set by the low address bits
						waitCnt <= bus.addr[1:0];
						okR     <= OK_HOLD;
						state   <= WAIT;
					end
				end
				WAIT:
				begin
					if (finish)
					begin
						okR   <= fault ? OK_FAULT : OK_OK;
						state <= DONE;
					end
					else
						waitCnt <= waitCnt - 2'd1;
				end
				default:
				begin
					if (bus.opm == OPM_READY)
					begin
						okR   <= OK_READY;
						state <= STORE_IDLE;
					end
				end
			endcase
		end
	end

	// array access at completion of the wait
	always_ff @(posedge clock)
	begin
		if (finish && !fault && (bus.opm == OPM_STORE))
			mem[index] <= bus.outData;
		if (finish && !fault && (bus.opm == OPM_LOAD))
			inDataR <= mem[index];
	end

	assign bus.ok     = okR;
	assign bus.inData = inDataR;
	assign bus.busExc = busExcR;

endmodule

`default_nettype wire

//--- verilog/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem import memBusPkg::*;
(
	input logic        clock,
	input logic        reset,
	input busExcWord   excIn,

	input dataWord     cl1OutData,
	input wordAddr     cl1Addr,
	input opmCode      cl1Opm,
	output dataWord    cl1InData,
	output okCode      cl1Ok,
	output busExcWord  cl1BusExc,

	input dataWord     cl2OutData,
	input wordAddr     cl2Addr,
	input opmCode      cl2Opm,
	output dataWord    cl2InData,
	output okCode      cl2Ok,
	output busExcWord  cl2BusExc
);

	memBusIf cl1Bus ();
	memBusIf cl2Bus ();
	memBusIf memBus ();

	// client 1 pins
	assign cl1Bus.outData = cl1OutData;
	assign cl1Bus.addr    = cl1Addr;
	assign cl1Bus.opm     = cl1Opm;
	assign cl1InData      = cl1Bus.inData;
	assign cl1Ok          = cl1Bus.ok;
	assign cl1BusExc      = cl1Bus.busExc;

	// client 2 pins
	assign cl2Bus.outData = cl2OutData;
	assign cl2Bus.addr    = cl2Addr;
	assign cl2Bus.opm     = cl2Opm;
	assign cl2InData      = cl2Bus.inData;
	assign cl2Ok          = cl2Bus.ok;
	assign cl2BusExc      = cl2Bus.busExc;

	memJoin join_i
	(
		.clock (clock),
		.reset (reset),
		.cl1   (cl1Bus.memory),
		.cl2   (cl2Bus.memory),
		.mem   (memBus.client)
	);

	memStore store_i
	(
		.clock (clock),
		.reset (reset),
		.bus   (memBus.memory),
		.excIn (excIn)
	);

endmodule

`default_nettype wire
